// File: compile.f
+incdir+design
design/scan_pkg.sv
design/line_buffer.sv
design/line_writer.sv
design/scan_sequencer.sv
design/vsync_timer.sv
design/pixel_mixer.sv
design/scan_doubler_top.sv
tb/tb_scan_doubler.sv

// File: design/line_buffer.sv
`include "scan_config.svh"

module line_buffer (
	input  logic                      clkvga,
	input  logic                      wr_en,
	input  logic [`SCAN_ADDR_W:0]     wr_addr,
	input  scan_pkg::pixel_word_u     wr_data,
	input  logic [`SCAN_ADDR_W:0]     rd_addr,
	output scan_pkg::pixel_word_u     rd_data
);

	// Two line halves, top address bit picks the half
	logic [$bits(scan_pkg::pixel_word_u)-1:0] mem [0:(1 << (`SCAN_ADDR_W + 1)) - 1];

	// Write port, fed from the source side
	always_ff @(posedge clkvga) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data.raw;
		end
	end

	// Registered read port
	// Data shows up one cycle after rd_addr
	always_ff @(posedge clkvga) begin
		rd_data.raw <= mem[rd_addr];
	end

endmodule

// File: design/line_writer.sv
`include "scan_config.svh"

module line_writer (
	input  logic                      clkvga,
	input  logic                      rst_n,
	input  logic [2:0]                r_in,
	input  logic [2:0]                g_in,
	input  logic [2:0]                b_in,
	input  logic                      pix_valid,
	input  logic                      hsync_in_n,
	output logic                      wr_en,
	output logic [`SCAN_ADDR_W:0]     wr_addr,
	output scan_pkg::pixel_word_u     wr_data,
	output logic [`SCAN_ADDR_W-1:0]   line_len,
	output logic                      line_done
);

	// Shortest line that a source hsync may close
	localparam logic [`SCAN_ADDR_W-1:0] MIN_COL = `SCAN_MIN_LINE;

	// Half currently being filled
	logic wr_half;
	// Next write column inside that half
	logic [`SCAN_ADDR_W-1:0] col;
	// Accepted end of a source line
	logic line_end;

	// Hsync only counts once the line is long enough
	assign line_end = ~hsync_in_n && (col >= MIN_COL);

	//////////////////////////////////////////////////////////////////////
	// Column and half tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			wr_half   <= 1'b0;
			col       <= '0;
			wr_en     <= 1'b0;
			line_done <= 1'b0;
			line_len  <= '0;
		end else begin
			// Write strobe trails the pixel strobe by one cycle
			wr_en     <= pix_valid;
			line_done <= line_end;
			if (line_end) begin
				// Column count is the pixel count of the finished line
				line_len <= col;
				col      <= '0;
				wr_half  <= ~wr_half;
			end else if (pix_valid) begin
				col <= col + 1'b1;
			end
		end
	end

	// Address and pixel word captured alongside wr_en
	always_ff @(posedge clkvga) begin
		wr_addr         <= {wr_half, col};
		wr_data.rgb.r   <= r_in;
		wr_data.rgb.g   <= g_in;
		wr_data.rgb.b   <= b_in;
	end

endmodule

// File: design/pixel_mixer.sv
`include "scan_config.svh"

module pixel_mixer (
	input  logic                      clkvga,
	input  logic                      rst_n,
	input  logic                      enable_scandoubling,
	input  logic                      disable_scaneffect,
	input  scan_pkg::pixel_word_u     rd_data,
	input  logic [`SCAN_ADDR_W-1:0]   rd_col,
	input  logic                      dim,
	input  logic                      active,
	input  logic                      vsync_vga,
	input  logic [2:0]                r_in,
	input  logic [2:0]                g_in,
	input  logic [2:0]                b_in,
	input  logic                      hsync_in_n,
	input  logic                      vsync_in_n,
	output logic [2:0]                r_out,
	output logic [2:0]                g_out,
	output logic [2:0]                b_out,
	output logic                      hsync_out,
	output logic                      vsync_out
);

	// Column where VGA hsync goes back high
	localparam logic [`SCAN_ADDR_W-1:0] HSYNC_END = `SCAN_HSYNC_COUNT;

	// Sequencer outputs lined up with the registered read data
	logic [`SCAN_ADDR_W-1:0] rd_col_q;
	logic                    dim_q;
	logic                    active_q;

	scan_pkg::rgb_t pix;
	logic [2:0]     r_vga;
	logic [2:0]     g_vga;
	logic [2:0]     b_vga;
	logic           hsync_vga;

	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			rd_col_q <= '0;
			dim_q    <= 1'b0;
			active_q <= 1'b0;
		end else begin
			rd_col_q <= rd_col;
			dim_q    <= dim;
			active_q <= active;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// VGA pixel path
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		pix = rd_data.rgb;
		if (!active_q) begin
			// Nothing stored yet, keep the screen black
			r_vga = '0;
			g_vga = '0;
			b_vga = '0;
		end else if (dim_q && !disable_scaneffect) begin
			// Scanline pass at half brightness
			r_vga = {1'b0, pix.r[2:1]};
			g_vga = {1'b0, pix.g[2:1]};
			b_vga = {1'b0, pix.b[2:1]};
		end else begin
			r_vga = pix.r;
			g_vga = pix.g;
			b_vga = pix.b;
		end
		// Low for the first columns of every pass
		hsync_vga = ~(active_q && (rd_col_q < HSYNC_END));
	end

	// Output registers, mode picked every cycle
	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			r_out     <= '0;
			g_out     <= '0;
			b_out     <= '0;
			hsync_out <= 1'b1;
			vsync_out <= 1'b1;
		end else if (enable_scandoubling) begin
			r_out     <= r_vga;
			g_out     <= g_vga;
			b_out     <= b_vga;
			hsync_out <= hsync_vga;
			vsync_out <= vsync_vga;
		end else begin
			// 15 kHz bypass with composite sync on hsync
			r_out     <= r_in;
			g_out     <= g_in;
			b_out     <= b_in;
			hsync_out <= hsync_in_n ^ ~vsync_in_n;
			vsync_out <= 1'b1;
		end
	end

endmodule

// File: design/scan_config.svh
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Scan doubler sizing
//////////////////////////////////////////////////////////////////////

// Column address width of one line half
// 10 bits gives 1024 columns per half, 2048 words in the buffer
`define SCAN_ADDR_W 10

// Write column a line must reach before source hsync ends it
// Short pulses below this are treated as glitches
`define SCAN_MIN_LINE 128

// Read columns at the start of each VGA line with hsync low
`define SCAN_HSYNC_COUNT 80

// VGA vsync low time in clkvga cycles, minus one
`define SCAN_VSYNC_COUNT 2743

`endif

// File: design/scan_doubler_top.sv
`include "scan_config.svh"

module scan_doubler_top (
	input  logic       clkvga,
	input  logic       rst_n,
	input  logic       enable_scandoubling,
	input  logic       disable_scaneffect,
	input  logic [2:0] r_in,
	input  logic [2:0] g_in,
	input  logic [2:0] b_in,
	input  logic       pix_valid,
	input  logic       hsync_in_n,
	input  logic       vsync_in_n,
	output logic [2:0] r_out,
	output logic [2:0] g_out,
	output logic [2:0] b_out,
	output logic       hsync_out,
	output logic       vsync_out
);

	// Write side
	logic                      wr_en;
	logic [`SCAN_ADDR_W:0]     wr_addr;
	scan_pkg::pixel_word_u     wr_data;
	logic [`SCAN_ADDR_W-1:0]   line_len;
	logic                      line_done;

	// Read side
	logic [`SCAN_ADDR_W:0]     rd_addr;
	scan_pkg::pixel_word_u     rd_data;
	logic [`SCAN_ADDR_W-1:0]   rd_col;
	logic                      dim;
	logic                      active;

	// VGA vertical sync
	logic                      vsync_vga;

	//////////////////////////////////////////////////////////////////////
	// Source line capture
	//////////////////////////////////////////////////////////////////////

	line_writer u_line_writer (
		.clkvga     (clkvga),
		.rst_n      (rst_n),
		.r_in       (r_in),
		.g_in       (g_in),
		.b_in       (b_in),
		.pix_valid  (pix_valid),
		.hsync_in_n (hsync_in_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.line_len   (line_len),
		.line_done  (line_done)
	);

	line_buffer u_line_buffer (
		.clkvga  (clkvga),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Double-rate replay and sync generation
	//////////////////////////////////////////////////////////////////////

	scan_sequencer u_scan_sequencer (
		.clkvga    (clkvga),
		.rst_n     (rst_n),
		.line_done (line_done),
		.line_len  (line_len),
		.rd_addr   (rd_addr),
		.rd_col    (rd_col),
		.dim       (dim),
		.active    (active)
	);

	vsync_timer u_vsync_timer (
		.clkvga     (clkvga),
		.rst_n      (rst_n),
		.vsync_in_n (vsync_in_n),
		.vsync_vga  (vsync_vga)
	);

	// Output stage, also holds the bypass path
	pixel_mixer u_pixel_mixer (
		.clkvga              (clkvga),
		.rst_n               (rst_n),
		.enable_scandoubling (enable_scandoubling),
		.disable_scaneffect  (disable_scaneffect),
		.rd_data             (rd_data),
		.rd_col              (rd_col),
		.dim                 (dim),
		.active              (active),
		.vsync_vga           (vsync_vga),
		.r_in                (r_in),
		.g_in                (g_in),
		.b_in                (b_in),
		.hsync_in_n          (hsync_in_n),
		.vsync_in_n          (vsync_in_n),
		.r_out               (r_out),
		.g_out               (g_out),
		.b_out               (b_out),
		.hsync_out           (hsync_out),
		.vsync_out           (vsync_out)
	);

endmodule

// File: design/scan_pkg.sv
package scan_pkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel formats
	//////////////////////////////////////////////////////////////////////

	// One retro pixel, 3 bits per channel
	// Field order keeps red in the top bits of the word
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb_t;

	// Same 9-bit word seen two ways
	// Raw view for the line memory
	// Channel view for packing and dimming
	typedef union packed {
		logic [8:0] raw;
		rgb_t       rgb;
	} pixel_word_u;

endpackage

// File: design/scan_sequencer.sv
`include "scan_config.svh"

module scan_sequencer (
	input  logic                      clkvga,
	input  logic                      rst_n,
	input  logic                      line_done,
	input  logic [`SCAN_ADDR_W-1:0]   line_len,
	output logic [`SCAN_ADDR_W:0]     rd_addr,
	output logic [`SCAN_ADDR_W-1:0]   rd_col,
	output logic                      dim,
	output logic                      active
);

	// State codes
	localparam logic [1:0] WAIT_LINE = 2'd0;
	localparam logic [1:0] PLAY      = 2'd1;
	localparam logic [1:0] REPLAY    = 2'd2;

	logic [1:0]               state;
	// Half being replayed
	logic                     rd_half;
	// Read column inside the half
	logic [`SCAN_ADDR_W-1:0]  col;
	// Last column of a pass
	logic [`SCAN_ADDR_W-1:0]  last_col;
	logic                     pass_end;

	assign last_col = line_len - 1'b1;
	assign pass_end = (col == last_col);

	//////////////////////////////////////////////////////////////////////
	// Read FSM
	//////////////////////////////////////////////////////////////////////

	// Writer starts in half 0, so the read half starts at 1
	// and toggles in step with it on every line_done
	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			state   <= WAIT_LINE;
			rd_half <= 1'b1;
			col     <= '0;
		end else if (line_done) begin
			// New line stored, replay the half the writer just left
			state   <= PLAY;
			rd_half <= ~rd_half;
			col     <= '0;
		end else begin
			case (state)
				WAIT_LINE: begin
					col <= '0;
				end
				PLAY: begin
					// Full brightness pass
					if (pass_end) begin
						state <= REPLAY;
						col   <= '0;
					end else begin
						col <= col + 1'b1;
					end
				end
				REPLAY: begin
					// Dimmed pass, then loop on the same half
					// in case the next source hsync is late
					if (pass_end) begin
						state <= PLAY;
						col   <= '0;
					end else begin
						col <= col + 1'b1;
					end
				end
				default: begin
					state <= WAIT_LINE;
					col   <= '0;
				end
			endcase
		end
	end

	// Outputs straight from the state registers
	assign rd_addr = {rd_half, col};
	assign rd_col  = col;
	assign dim     = (state == REPLAY);
	assign active  = (state == PLAY) || (state == REPLAY);

endmodule

// File: design/vsync_timer.sv
`include "scan_config.svh"

module vsync_timer (
	input  logic clkvga,
	input  logic rst_n,
	input  logic vsync_in_n,
	output logic vsync_vga
);

	// Idle means armed and waiting for a falling source vsync
	localparam logic [15:0] CNT_IDLE = 16'hFFFF;
	// Done means pulse sent, waiting for source vsync to go high
	localparam logic [15:0] CNT_DONE = 16'hFFFE;
	// Last count of the low pulse
	localparam logic [15:0] CNT_LAST = `SCAN_VSYNC_COUNT;

	logic [15:0] cnt;

	//////////////////////////////////////////////////////////////////////
	// Pulse counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= CNT_IDLE;
			vsync_vga <= 1'b1;
		end else if (cnt == CNT_IDLE) begin
			// First low sample starts the pulse
			if (!vsync_in_n) begin
				cnt       <= '0;
				vsync_vga <= 1'b0;
			end
		end else if (cnt == CNT_DONE) begin
			// Rearm only once the source vsync is over
			if (vsync_in_n) begin
				cnt <= CNT_IDLE;
			end
		end else if (cnt == CNT_LAST) begin
			vsync_vga <= 1'b1;
			cnt       <= CNT_DONE;
		end else begin
			// Keeps running even if source vsync ends early
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the scan doubler testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_scan_doubler \
	> sim.log 2>&1 || { echo "Verilator build failed, see sim.log"; exit 1; }
./obj_dir/Vtb_scan_doubler >> sim.log 2>&1
grep -q "Simulation FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a result, see sim.log"; exit 1; }
echo "Test passed"

// File: tb/tb_scan_doubler.sv
`include "scan_config.svh"

module tb_scan_doubler;

	logic       clkvga;
	logic       rst_n;
	logic       enable_scandoubling;
	logic       disable_scaneffect;
	logic [2:0] r_in;
	logic [2:0] g_in;
	logic [2:0] b_in;
	logic       pix_valid;
	logic       hsync_in_n;
	logic       vsync_in_n;
	logic [2:0] r_out;
	logic [2:0] g_out;
	logic [2:0] b_out;
	logic       hsync_out;
	logic       vsync_out;

	// Per row doubling on, dimming off, line count, pixels per line,
	// hsync width and whether a source vsync comes first
	int stim [0:4][0:5] = '{
		'{1, 0, 3, 200, 40, 1},
		'{1, 1, 2, 320, 90, 0},
		'{0, 0, 2, 256, 30, 1},
		'{1, 0, 2, 400, 20, 1},
		'{1, 1, 2, 233, 60, 0}
	};

	// Rising edges seen so far
	int          cyc = 0;
	// Falling-edge cycle of the last source vsync
	int          vs_fall = -100000;
	int          lines_pushed = 0;
	int          lines_checked = 0;
	logic [15:0] lfsr = 16'd96;

	// Doubled lines handed from the driver to the output checker
	int          start_q [$];
	int          len_q [$];
	bit          nodim_q [$];
	logic [8:0]  pix_q [$];
	logic [8:0]  model_line [0:1023];

	scan_doubler_top u_scan_doubler_top (.*);

	initial begin
		clkvga = 1'b0;
		forever #2 clkvga = ~clkvga;
	end

	always @(posedge clkvga) cyc <= cyc + 1;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic expect_equal(input string name, input logic [8:0] got, input logic [8:0] exp);
		assert (got === exp)
		else stop_with_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Channel by channel, red in the top bits
	task automatic compare_rgb(input logic [8:0] exp);
		expect_equal("r_out", {6'd0, r_out}, {6'd0, exp[8:6]});
		expect_equal("g_out", {6'd0, g_out}, {6'd0, exp[5:3]});
		expect_equal("b_out", {6'd0, b_out}, {6'd0, exp[2:0]});
	endtask

	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Nine LFSR bits make one pixel
	function automatic logic [8:0] random_pixel();
		logic [8:0] v;
		v = '0;
		for (int i = 0; i < 9; i++) begin
			v = {v[7:0], lfsr[15]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// Outputs sampled on the falling edge after the rising edge that set them
	task automatic next_cycle();
		logic vs_exp;
		@(negedge clkvga);
		// VGA vsync is low for COUNT+1 cycles from 2 cycles after the source edge
		vs_exp = 1'b1;
		if (enable_scandoubling && cyc - vs_fall >= 2 && cyc - vs_fall <= `SCAN_VSYNC_COUNT + 2)
			vs_exp = 1'b0;
		expect_equal("vsync_out", {8'd0, vsync_out}, {8'd0, vs_exp});
		// Bypass shows the inputs one cycle late
		if (!enable_scandoubling) begin
			compare_rgb({r_in, g_in, b_in});
			// Composite sync is high while both source syncs agree
			expect_equal("hsync_out", {8'd0, hsync_out}, {8'd0, hsync_in_n == vsync_in_n});
		end
	endtask

	// Pixels on alternate cycles, then source hsync
	task automatic send_line(input int npix, input int hsw, input bit dbl, input bit nodim);
		logic [8:0] px;
		for (int p = 0; p < npix; p++) begin
			next_cycle();
			px = random_pixel();
			{r_in, g_in, b_in} = px;
			pix_valid = 1'b1;
			if (dbl) pix_q.push_back(px);
			next_cycle();
			pix_valid = 1'b0;
		end
		next_cycle();
		hsync_in_n = 1'b0;
		if (dbl) begin
			// First pixel out after line_done, sequencer, buffer and output registers
			start_q.push_back(cyc + 4);
			len_q.push_back(npix);
			nodim_q.push_back(nodim);
			lines_pushed++;
		end
		repeat (hsw) next_cycle();
		hsync_in_n = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output checker for doubled lines
	//////////////////////////////////////////////////////////////////////

	task automatic check_line();
		int         t;
		int         s;
		int         n;
		int         c;
		bit         nodim;
		logic [8:0] p;
		logic [8:0] exp_rgb;
		t = 0;
		while (start_q.size() == 0) begin
			@(negedge clkvga);
			t++;
			assert (t < 100000) else stop_with_error("Timed out waiting for a source line to end");
		end
		s = start_q.pop_front();
		n = len_q.pop_front();
		nodim = nodim_q.pop_front();
		for (int i = 0; i < n; i++) model_line[i] = pix_q.pop_front();
		t = 0;
		while (cyc < s) begin
			@(negedge clkvga);
			t++;
			assert (t < 16) else stop_with_error("Timed out waiting for an output line to start");
		end
		assert (cyc == s) else stop_with_error("Output line start was missed");
		// Full pass, then the scanline pass
		for (int i = 0; i < 2 * n; i++) begin
			if (i > 0) @(negedge clkvga);
			c = i % n;
			p = model_line[c];
			if (i >= n && !nodim) exp_rgb = {1'b0, p[8:7], 1'b0, p[5:4], 1'b0, p[2:1]};
			else exp_rgb = p;
			compare_rgb(exp_rgb);
			expect_equal("hsync_out", {8'd0, hsync_out},
				(c < `SCAN_HSYNC_COUNT) ? 9'd0 : 9'd1);
		end
		lines_checked++;
	endtask

	initial begin
		forever check_line();
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int t;
		rst_n = 1'b0;
		enable_scandoubling = 1'b1;
		disable_scaneffect = 1'b0;
		{r_in, g_in, b_in} = 9'd0;
		pix_valid = 1'b0;
		hsync_in_n = 1'b1;
		vsync_in_n = 1'b1;
		repeat (5) @(posedge clkvga);
		@(negedge clkvga);
		rst_n = 1'b1;
		// Black screen with idle syncs until a line is stored
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			compare_rgb(9'd0);
			expect_equal("hsync_out", {8'd0, hsync_out}, 9'd1);
		end
		for (int r = 0; r < 5; r++) begin
			enable_scandoubling = (stim[r][0] != 0);
			disable_scaneffect = (stim[r][1] != 0);
			if (stim[r][5] != 0) begin
				// Previous VGA vsync pulse ends before the next source vsync
				while (cyc < vs_fall + 2800) next_cycle();
				vsync_in_n = 1'b0;
				vs_fall = cyc;
				repeat (4) next_cycle();
				// Short hsync inside vsync, too early in the line to end it
				hsync_in_n = 1'b0;
				repeat (8) next_cycle();
				hsync_in_n = 1'b1;
				repeat (4) next_cycle();
				vsync_in_n = 1'b1;
				repeat (16) next_cycle();
			end
			for (int l = 0; l < stim[r][2]; l++)
				send_line(stim[r][3], stim[r][4], stim[r][0] != 0, stim[r][1] != 0);
			t = 0;
			while (lines_checked != lines_pushed) begin
				next_cycle();
				t++;
				assert (t < 4000) else stop_with_error("Timed out waiting for output lines");
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule
